// ==== tb.f ====
+incdir+design
design/decoderPkg.sv
design/specialDecoder.sv
design/mulExtDecoder.sv
design/immDecoder.sv
design/decodeStage.sv
sim/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module decodeStageTb -o decodeStageTbSim \
    && ./obj_dir/decodeStageTbSim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

// ==== sim/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module decodeStageTb;
    import decoderPkg::*;

    // limit leaves headroom over about 255 cycles of stimulus
    localparam int maxCycles = 400;

    // SPECIAL function codes in the decode table
    localparam logic [5:0] specFuncts [0:22] = '{
        6'b000000, 6'b000010, 6'b000011, 6'b100000, 6'b100001, 6'b100010,
        6'b100100, 6'b100101, 6'b100111, 6'b100110, 6'b000100, 6'b000110,
        6'b000111, 6'b101010, 6'b101011, 6'b001011, 6'b001010, 6'b010000,
        6'b010010, 6'b011000, 6'b011001, 6'b010001, 6'b010011
    };
    // I-type opcodes for building stimulus
    localparam logic [5:0] immOps [0:6] = '{
        6'b001000, 6'b001001, 6'b001010, 6'b001011, 6'b001100, 6'b001101, 6'b001110
    };

    logic                clk;
    logic                rstN;
    logic                instValid;
    logic [`INSTR_W-1:0] instr;
    logic                ctrlValid;
    ctrlT                ctrl;

    // one-deep expected register
    logic                expValid;
    ctrlT                expCtrl;
    logic [`INSTR_W-1:0] expInstr;

    integer              seed;
    int                  cycleCount;

    decodeStage dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instr     (instr),
        .ctrlValid (ctrlValid),
        .ctrl      (ctrl)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // reference decode
    //////////////////////////////////////////////////////////////////////
    function automatic ctrlT makeBubble(input logic rsv);
        ctrlT c;
        c          = '0;
        c.reserved = rsv;
        c.aluOp    = ALU_ADD;
        return c;
    endfunction

    // register form writes rd
    function automatic ctrlT rShape(input aluOpT op, input logic wr, input logic sh);
        ctrlT c;
        c          = '0;
        c.regDst   = 1'b1;
        c.regWrite = wr;
        c.aluShamt = sh;
        c.aluOp    = op;
        return c;
    endfunction

    // immediate form writes rt
    function automatic ctrlT iShape(input aluOpT op, input logic zx);
        ctrlT c;
        c          = '0;
        c.aluSrc   = 1'b1;
        c.regWrite = 1'b1;
        c.zeroExt  = zx;
        c.aluOp    = op;
        return c;
    endfunction

    function automatic ctrlT refDecode(input logic [`INSTR_W-1:0] w);
        ctrlT       c;
        logic [5:0] op;
        logic [5:0] fn;
        aluOpT      srlOp;
        aluOpT      srlvOp;
        aluOpT      extOp;
        op = w[`OP_MSB:`OP_LSB];
        fn = w[`FUNCT_MSB:`FUNCT_LSB];
        // variant selects
        if (w[`ROT_BIT]) begin
            srlOp = ALU_ROTR;
        end else begin
            srlOp = ALU_SRL;
        end
        if (w[`ROTV_BIT]) begin
            srlvOp = ALU_ROTR;
        end else begin
            srlvOp = ALU_SRL;
        end
        if (w[`SEH_BIT]) begin
            extOp = ALU_SEH;
        end else begin
            extOp = ALU_SEB;
        end
        // anything unmatched stays a reserved bubble
        c = makeBubble(1'b1);
        if (w == '0) begin
            c = makeBubble(1'b0);
        end else if (op == 6'b000000) begin
            case (fn)
                6'b000000: c = rShape(ALU_SLL, 1'b1, 1'b1);
                6'b000010: c = rShape(srlOp, 1'b1, 1'b1);
                6'b000011: c = rShape(ALU_SRA, 1'b1, 1'b1);
                6'b100000: c = rShape(ALU_ADD, 1'b1, 1'b0);
                6'b100001: c = rShape(ALU_ADDU, 1'b1, 1'b0);
                6'b100010: c = rShape(ALU_SUB, 1'b1, 1'b0);
                6'b100100: c = rShape(ALU_AND, 1'b1, 1'b0);
                6'b100101: c = rShape(ALU_OR, 1'b1, 1'b0);
                6'b100111: c = rShape(ALU_NOR, 1'b1, 1'b0);
                6'b100110: c = rShape(ALU_XOR, 1'b1, 1'b0);
                6'b000100: c = rShape(ALU_SLL, 1'b1, 1'b0);
                6'b000110: c = rShape(srlvOp, 1'b1, 1'b0);
                6'b000111: c = rShape(ALU_SRA, 1'b1, 1'b0);
                6'b101010: c = rShape(ALU_SLT, 1'b1, 1'b0);
                6'b101011: c = rShape(ALU_SLTU, 1'b1, 1'b0);
                6'b001011: c = rShape(ALU_MOVN, 1'b1, 1'b0);
                6'b001010: c = rShape(ALU_MOVZ, 1'b1, 1'b0);
                6'b010000: c = rShape(ALU_MFHI, 1'b1, 1'b0);
                6'b010010: c = rShape(ALU_MFLO, 1'b1, 1'b0);
                // hi/lo side only
                6'b011000: c = rShape(ALU_MULT, 1'b0, 1'b0);
                6'b011001: c = rShape(ALU_MULTU, 1'b0, 1'b0);
                6'b010001: c = rShape(ALU_MTHI, 1'b0, 1'b0);
                6'b010011: c = rShape(ALU_MTLO, 1'b0, 1'b0);
                default:   c = makeBubble(1'b1);
            endcase
        end else if (op == 6'b011100) begin
            case (fn)
                6'b000010: c = rShape(ALU_MUL, 1'b1, 1'b0);
                6'b000000: c = rShape(ALU_MADD, 1'b0, 1'b0);
                6'b000100: c = rShape(ALU_MSUB, 1'b0, 1'b0);
                default:   c = makeBubble(1'b1);
            endcase
        end else if (op == 6'b011111) begin
            c = rShape(extOp, 1'b1, 1'b0);
        end else begin
            case (op)
                6'b001000: c = iShape(ALU_ADD, 1'b0);
                6'b001001: c = iShape(ALU_ADDU, 1'b0);
                6'b001010: c = iShape(ALU_SLT, 1'b0);
                6'b001011: c = iShape(ALU_SLTU, 1'b1);
                6'b001100: c = iShape(ALU_AND, 1'b1);
                6'b001101: c = iShape(ALU_OR, 1'b1);
                6'b001110: c = iShape(ALU_XOR, 1'b1);
                default:   c = makeBubble(1'b1);
            endcase
        end
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking and driving
    //////////////////////////////////////////////////////////////////////
    task automatic checkOutputs;
        assert (ctrlValid === expValid) else begin
            $display("[FAIL] ctrlValid: got 0x%0h, expected 0x%0h", ctrlValid, expValid);
            $display("SIMULATION FAILED");
            $fatal(1, "ctrlValid mismatch");
        end
        assert (ctrl === expCtrl) else begin
            $display("[FAIL] ctrl: got 0x%03h, expected 0x%03h, instr 0x%08h",
                     ctrl, expCtrl, expInstr);
            $display("SIMULATION FAILED");
            $fatal(1, "ctrl mismatch");
        end
    endtask

    // check last cycle's result, then drive the next item
    task automatic step(input logic v, input logic [`INSTR_W-1:0] w);
        @(negedge clk);
        checkOutputs();
        instValid = v;
        instr     = w;
        expValid  = v;
        // idle cycles keep the old word
        if (v) begin
            expCtrl  = refDecode(w);
            expInstr = w;
        end
    endtask

    // timeout watchdog
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [31:0] w;
        int          idx;
        seed       = 26420;
        cycleCount = 0;
        rstN       = 1'b0;
        instValid  = 1'b0;
        instr      = '0;
        expValid   = 1'b0;
        expCtrl    = '0;
        expInstr   = '0;

        // outputs cleared after reset
        repeat (2) @(negedge clk);
        checkOutputs();
        rstN = 1'b1;

        // every SPECIAL function with random register fields
        for (idx = 0; idx < 23; idx++) begin
            r = $random(seed);
            step(1'b1, {6'b000000, r[25:6], specFuncts[idx]});
        end
        // sll against sllv shamt source
        step(1'b1, {6'b000000, 5'd0, 5'd3, 5'd4, 5'd7, 6'b000000});
        step(1'b1, {6'b000000, 5'd2, 5'd3, 5'd4, 5'd0, 6'b000100});
        // srl/rotr by bit 21, srlv/rotrv by bit 6
        step(1'b1, {6'b000000, 5'd0, 5'd5, 5'd6, 5'd9, 6'b000010});
        step(1'b1, {6'b000000, 5'd1, 5'd5, 5'd6, 5'd9, 6'b000010});
        step(1'b1, {6'b000000, 5'd7, 5'd5, 5'd6, 5'd0, 6'b000110});
        step(1'b1, {6'b000000, 5'd7, 5'd5, 5'd6, 5'd1, 6'b000110});
        // seh and seb in the bshfl function
        step(1'b1, {6'b011111, 5'd0, 5'd8, 5'd9, 5'b11000, 6'b100000});
        step(1'b1, {6'b011111, 5'd0, 5'd8, 5'd9, 5'b10000, 6'b100000});
        // mul, madd, msub
        step(1'b1, {6'b011100, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000010});
        step(1'b1, {6'b011100, 5'd1, 5'd2, 5'd0, 5'd0, 6'b000000});
        step(1'b1, {6'b011100, 5'd1, 5'd2, 5'd0, 5'd0, 6'b000100});

        // all I-type opcodes
        for (idx = 0; idx < 7; idx++) begin
            r = $random(seed);
            step(1'b1, {immOps[idx], r[25:0]});
        end

        // nop, then encodings nobody claims
        step(1'b1, 32'h0000_0000);
        r = $random(seed);
        step(1'b1, {6'b100011, r[25:0]});
        step(1'b1, {6'b000100, r[25:0]});
        step(1'b1, {6'b000010, r[25:0]});
        step(1'b1, {6'b000000, r[25:6], 6'b001000});
        step(1'b1, {6'b000000, r[25:6], 6'b111111});
        step(1'b1, {6'b011100, r[25:6], 6'b100000});
        step(1'b1, {6'b011100, r[25:6], 6'b000001});

        // random mix with valid toggling at random
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            w = $random(seed);
            case (r[3:1])
                3'd0: begin
                    idx      = r[15:8] % 23;
                    w[31:26] = 6'b000000;
                    w[5:0]   = specFuncts[idx];
                end
                3'd1: w[31:26] = 6'b011100;
                3'd2: w[31:26] = 6'b011111;
                3'd3, 3'd4: begin
                    idx      = r[15:8] % 7;
                    w[31:26] = immOps[idx];
                end
                default: ;
            endcase
            step(r[0], w);
        end

        // drain the last item and one idle cycle
        step(1'b0, '0);
        @(negedge clk);
        checkOutputs();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instValid,
    input  logic [`INSTR_W-1:0] instr,
    output logic                ctrlValid,
    output decoderPkg::ctrlT    ctrl
);
    import decoderPkg::*;

    decodeResultT specRes;
    decodeResultT mulRes;
    decodeResultT immRes;
    ctrlT         nextCtrl;

    //////////////////////////////////////////////////////////////////////
    // per-class decoders are all combinational
    //////////////////////////////////////////////////////////////////////
    specialDecoder specDec0 (
        .instr  (instr),
        .result (specRes)
    );

    mulExtDecoder mulDec0 (
        .instr  (instr),
        .result (mulRes)
    );

    immDecoder immDec0 (
        .instr  (instr),
        .result (immRes)
    );

    // opcode classes are disjoint so at most one hit
    always_comb begin
        if (specRes.hit) begin
            nextCtrl = specRes.ctrl;
        end else if (mulRes.hit) begin
            nextCtrl = mulRes.ctrl;
        end else if (immRes.hit) begin
            nextCtrl = immRes.ctrl;
        end else begin
            // opcode nobody claims
            nextCtrl = bubbleCtrl(1'b1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pipeline register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
        end else begin
            ctrlValid <= instValid;
            // hold last word while idle
            if (instValid) begin
                ctrl <= nextCtrl;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/immDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module immDecoder (
    input  logic [`INSTR_W-1:0]      instr,
    output decoderPkg::decodeResultT result
);
    import decoderPkg::*;

    ctrlT ctrlW;

    always_comb begin
        // immediate form writes rt
        ctrlW          = '0;
        ctrlW.aluSrc   = 1'b1;
        ctrlW.regWrite = 1'b1;
        ctrlW.aluOp    = ALU_ADD;
        result.hit     = 1'b1;

        case (opcodeT'(instr[`OP_MSB:`OP_LSB]))
            // sign-extended immediates
            OP_ADDI:  ctrlW.aluOp = ALU_ADD;
            OP_ADDIU: ctrlW.aluOp = ALU_ADDU;
            OP_SLTI:  ctrlW.aluOp = ALU_SLT;
            // logic ops take a zero-extended immediate
            OP_ANDI: begin
                ctrlW.aluOp   = ALU_AND;
                ctrlW.zeroExt = 1'b1;
            end
            OP_ORI: begin
                ctrlW.aluOp   = ALU_OR;
                ctrlW.zeroExt = 1'b1;
            end
            OP_XORI: begin
                ctrlW.aluOp   = ALU_XOR;
                ctrlW.zeroExt = 1'b1;
            end
            // sltiu compares unsigned against zero-extended imm here
            OP_SLTIU: begin
                ctrlW.aluOp   = ALU_SLTU;
                ctrlW.zeroExt = 1'b1;
            end
            default: begin
                result.hit = 1'b0;
                ctrlW      = bubbleCtrl(1'b1);
            end
        endcase

        result.ctrl = ctrlW;
    end

endmodule

`default_nettype wire

// ==== design/mulExtDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module mulExtDecoder (
    input  logic [`INSTR_W-1:0]      instr,
    output decoderPkg::decodeResultT result
);
    import decoderPkg::*;

    logic [`FUNCT_MSB-`FUNCT_LSB:0] funct;
    ctrlT                           ctrlW;

    assign funct = instr[`FUNCT_MSB:`FUNCT_LSB];

    always_comb begin
        // register-register shape shared by both classes
        ctrlW          = '0;
        ctrlW.regDst   = 1'b1;
        ctrlW.regWrite = 1'b1;
        ctrlW.aluOp    = ALU_ADD;
        result.hit     = 1'b1;

        case (opcodeT'(instr[`OP_MSB:`OP_LSB]))
            OP_SPECIAL2: begin
                case (funct)
                    6'b000010: ctrlW.aluOp = ALU_MUL;
                    // madd/msub accumulate into hi/lo
                    6'b000000: begin
                        ctrlW.aluOp    = ALU_MADD;
                        ctrlW.regWrite = 1'b0;
                    end
                    6'b000100: begin
                        ctrlW.aluOp    = ALU_MSUB;
                        ctrlW.regWrite = 1'b0;
                    end
                    default: ctrlW = bubbleCtrl(1'b1);
                endcase
            end
            OP_SPECIAL3: begin
                // only seh and seb of the bshfl group kept
                if (instr[`SEH_BIT]) begin
                    ctrlW.aluOp = ALU_SEH;
                end else begin
                    ctrlW.aluOp = ALU_SEB;
                end
            end
            default: begin
                result.hit = 1'b0;
                ctrlW      = bubbleCtrl(1'b1);
            end
        endcase

        result.ctrl = ctrlW;
    end

endmodule

`default_nettype wire

// ==== design/specialDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decoder_settings.svh"

module specialDecoder (
    input  logic [`INSTR_W-1:0]      instr,
    output decoderPkg::decodeResultT result
);
    import decoderPkg::*;

    logic [`FUNCT_MSB-`FUNCT_LSB:0] funct;
    logic [`OP_MSB-`OP_LSB:0]       opcode;
    ctrlT                           known;     // decode of a listed function
    logic                           isKnown;

    assign funct  = instr[`FUNCT_MSB:`FUNCT_LSB];
    assign opcode = instr[`OP_MSB:`OP_LSB];

    //////////////////////////////////////////////////////////////////////
    // function field table
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        // common R-type shape
        known          = '0;
        known.regDst   = 1'b1;
        known.regWrite = 1'b1;
        known.aluOp    = ALU_ADD;
        isKnown        = 1'b1;

        case (funct)
            // immediate shifts
            6'b000000: begin
                known.aluOp    = ALU_SLL;
                known.aluShamt = 1'b1;
            end
            6'b000010: begin
                // rotr when the rs field lsb is set
                if (instr[`ROT_BIT]) begin
                    known.aluOp = ALU_ROTR;
                end else begin
                    known.aluOp = ALU_SRL;
                end
                known.aluShamt = 1'b1;
            end
            6'b000011: begin
                known.aluOp    = ALU_SRA;
                known.aluShamt = 1'b1;
            end
            // variable shifts take the amount from rs
            6'b000100: known.aluOp = ALU_SLL;
            6'b000110: begin
                if (instr[`ROTV_BIT]) begin
                    known.aluOp = ALU_ROTR;
                end else begin
                    known.aluOp = ALU_SRL;
                end
            end
            6'b000111: known.aluOp = ALU_SRA;
            // arithmetic
            6'b100000: known.aluOp = ALU_ADD;
            6'b100001: known.aluOp = ALU_ADDU;
            6'b100010: known.aluOp = ALU_SUB;
            // logic
            6'b100100: known.aluOp = ALU_AND;
            6'b100101: known.aluOp = ALU_OR;
            6'b100110: known.aluOp = ALU_XOR;
            6'b100111: known.aluOp = ALU_NOR;
            // compares and conditional moves
            6'b101010: known.aluOp = ALU_SLT;
            6'b101011: known.aluOp = ALU_SLTU;
            6'b001010: known.aluOp = ALU_MOVZ;
            6'b001011: known.aluOp = ALU_MOVN;
            // hi/lo reads write rd
            6'b010000: known.aluOp = ALU_MFHI;
            6'b010010: known.aluOp = ALU_MFLO;
            // hi/lo writers leave the gpr file alone
            6'b010001: begin
                known.aluOp    = ALU_MTHI;
                known.regWrite = 1'b0;
            end
            6'b010011: begin
                known.aluOp    = ALU_MTLO;
                known.regWrite = 1'b0;
            end
            6'b011000: begin
                known.aluOp    = ALU_MULT;
                known.regWrite = 1'b0;
            end
            6'b011001: begin
                known.aluOp    = ALU_MULTU;
                known.regWrite = 1'b0;
            end
            default: isKnown = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // class hit and final word
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        result.hit = (opcodeT'(opcode) == OP_SPECIAL);
        // all-zero word is sll r0 by encoding but means nop
        if (instr == '0) begin
            result.ctrl = bubbleCtrl(1'b0);
        end else if (!isKnown) begin
            result.ctrl = bubbleCtrl(1'b1);
        end else begin
            result.ctrl = known;
        end
    end

endmodule

`default_nettype wire

// ==== design/decoderPkg.sv ====
`default_nettype none

`include "decoder_settings.svh"

package decoderPkg;

    //////////////////////////////////////////////////////////////////////
    // major opcodes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [`OP_MSB-`OP_LSB:0] {
        OP_SPECIAL  = 6'b000000,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110,
        OP_SPECIAL2 = 6'b011100,
        OP_SPECIAL3 = 6'b011111
    } opcodeT;

    //////////////////////////////////////////////////////////////////////
    // alu operations with encodings shared by the execute stage
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [`ALUOP_W-1:0] {
        // arithmetic and multiply
        ALU_ADD   = 6'b000000, ALU_SUB  = 6'b000001,
        ALU_MUL   = 6'b000010, ALU_MULT = 6'b000011,
        ALU_MADD  = 6'b000100, ALU_MSUB = 6'b000101,
        // logic and sign extension
        ALU_AND   = 6'b001111, ALU_OR   = 6'b010000,
        ALU_NOR   = 6'b010001, ALU_XOR  = 6'b010010,
        ALU_SEH   = 6'b010011,
        // shifts, moves, compares
        ALU_SLL   = 6'b010100, ALU_SRL  = 6'b010101,
        ALU_MOVN  = 6'b010110, ALU_MOVZ = 6'b010111,
        ALU_ROTR  = 6'b011000, ALU_SRA  = 6'b011001,
        ALU_SEB   = 6'b011010, ALU_SLT  = 6'b011011,
        // hi/lo access
        ALU_MTHI  = 6'b011100, ALU_MTLO = 6'b011101,
        ALU_MFHI  = 6'b011110, ALU_MFLO = 6'b011111,
        // unsigned variants
        ALU_ADDU  = 6'b100000, ALU_MULTU = 6'b100001,
        ALU_SLTU  = 6'b100010
    } aluOpT;

    // 12-bit control word handed to execute
    typedef struct packed {
        logic  aluSrc;    // immediate is operand b
        logic  regDst;    // write rd, else rt
        logic  regWrite;
        logic  aluShamt;  // shift amount from shamt field
        logic  zeroExt;   // zero extend the immediate
        logic  reserved;  // unknown encoding
        aluOpT aluOp;
    } ctrlT;

    // per-class decoder output
    typedef struct packed {
        logic hit;        // instr belongs to this decoder's class
        ctrlT ctrl;
    } decodeResultT;

    // bubble writes nothing and adds as a harmless op
    function automatic ctrlT bubbleCtrl(input logic isReserved);
        ctrlT c;
        c          = '0;
        c.reserved = isReserved;
        c.aluOp    = ALU_ADD;
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== design/decoder_settings.svh ====
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// instruction word
`define INSTR_W 32

// major opcode field
`define OP_MSB 31
`define OP_LSB 26

// function field of the R-type formats
`define FUNCT_MSB 5
`define FUNCT_LSB 0

// variant select bits
// rotr vs srl lives in the rs field
`define ROT_BIT 21
// rotrv vs srlv lives in the shamt field
`define ROTV_BIT 6
// seh vs seb in SPECIAL3 bshfl
`define SEH_BIT 9

// alu operation code width
`define ALUOP_W 6

`endif
